//--- logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  //////////////////////////////////////////////////
  // Major opcodes
  //////////////////////////////////////////////////

  // RV base opcodes for integer loads and stores
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  //////////////////////////////////////////////////
  // Decoded operation
  //////////////////////////////////////////////////

  // Anything else on the opcode field is a bubble
  typedef enum logic [1:0] {
    LSU_OP_NONE  = 2'b00,
    LSU_OP_LOAD  = 2'b01,
    LSU_OP_STORE = 2'b10
  } lsu_op_e;

  // Access width, same as funct3[1:0]
  // funct3[2] carries the unsigned flag for loads
  typedef enum logic [1:0] {
    LSU_W_BYTE   = 2'b00,
    LSU_W_HALF   = 2'b01,
    LSU_W_WORD   = 2'b10,
    LSU_W_DOUBLE = 2'b11
  } lsu_width_e;

  //////////////////////////////////////////////////
  // Access sequencing
  //////////////////////////////////////////////////

  // One access in flight, wait for memory ack
  typedef enum logic {
    LSU_ST_IDLE     = 1'b0,
    LSU_ST_WAIT_ACK = 1'b1
  } lsu_state_e;

  //////////////////////////////////////////////////
  // Exception causes
  //////////////////////////////////////////////////

  // Illegal width wins over misalignment
  typedef enum logic [1:0] {
    LSU_CAUSE_LOAD_MISALIGNED  = 2'b00,
    LSU_CAUSE_STORE_MISALIGNED = 2'b01,
    LSU_CAUSE_ILLEGAL_WIDTH    = 2'b10
  } lsu_cause_e;

endpackage : lsu_pkg

`default_nettype wire

//--- logic/lsu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_decode
  import lsu_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  wire [31:0]      insn_i,
  output lsu_op_e         op_o,
  output lsu_width_e      width_o,
  output logic            unsigned_o,
  output logic            illegal_o,
  output logic [XLEN-1:0] imm_o
);

  // Width that fills a whole register
  localparam lsu_width_e XLEN_WIDTH = (XLEN == 64) ? LSU_W_DOUBLE : LSU_W_WORD;

  //////////////////////////////////////////////////
  // Instruction fields
  //////////////////////////////////////////////////

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [11:0] imm_itype;
  logic [11:0] imm_stype;
  logic        too_wide;
  logic        bad_unsigned;

  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];

  // I-form for loads
  assign imm_itype = insn_i[31:20];
  // S-form for stores, split around rs2
  assign imm_stype = {insn_i[31:25], insn_i[11:7]};

  //////////////////////////////////////////////////
  // Opcode and width
  //////////////////////////////////////////////////

  always_comb
  begin
    case (opcode)
      OPC_LOAD:  op_o = LSU_OP_LOAD;
      OPC_STORE: op_o = LSU_OP_STORE;
      default:   op_o = LSU_OP_NONE;
    endcase
  end

  assign width_o    = lsu_width_e'(funct3[1:0]);
  assign unsigned_o = funct3[2];

  // Double only exists on 64 bit
  assign too_wide = (XLEN == 32) && (width_o == LSU_W_DOUBLE);

  // No LWU on RV32, no LDU on RV64
  // Stores have no unsigned forms at all
  assign bad_unsigned = unsigned_o &&
                        ((width_o == XLEN_WIDTH) || (op_o == LSU_OP_STORE));

  // Only meaningful for memory opcodes
  assign illegal_o = (op_o != LSU_OP_NONE) && (too_wide || bad_unsigned);

  //////////////////////////////////////////////////
  // Immediate
  //////////////////////////////////////////////////

  always_comb
  begin
    if (op_o == LSU_OP_STORE)
    begin
      imm_o = XLEN'($signed(imm_stype));
    end
    else
    begin
      // Loads and bubbles alike
      imm_o = XLEN'($signed(imm_itype));
    end
  end

endmodule : lsu_decode

`default_nettype wire

//--- logic/lsu_issue.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_issue
  import lsu_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  wire                            clk_i,
  input  wire                            rst_ni,

  // Decoded instruction and operands
  input  wire                            insn_valid_i,
  input  wire lsu_op_e                   op_i,
  input  wire lsu_width_e                width_i,
  input  wire                            unsigned_i,
  input  wire                            illegal_i,
  input  wire [XLEN-1:0]                 imm_i,
  input  wire [XLEN-1:0]                 opa_i,
  input  wire [XLEN-1:0]                 opb_i,

  // Data memory
  output logic                           dmem_req_o,
  output logic                           dmem_we_o,
  output logic [XLEN-1:0]                dmem_adr_o,
  output logic [XLEN/8-1:0]              dmem_be_o,
  output logic [XLEN-1:0]                dmem_d_o,
  input  wire                            dmem_ack_i,

  output logic                           lsu_stall_o,

  // Load shape to the aligner
  output logic                           ld_start_o,
  output lsu_width_e                     ld_width_o,
  output logic                           ld_unsigned_o,
  output logic [$clog2(XLEN/8)-1:0]      ld_offset_o,

  output logic                           exc_valid_o,
  output lsu_cause_e                     exc_cause_o,
  output logic [XLEN-1:0]                exc_addr_o
);

  localparam int BEW  = XLEN / 8;
  localparam int OFFW = $clog2(BEW);

  lsu_state_e        state;
  logic [XLEN-1:0]   adr;
  logic [OFFW-1:0]   offset;
  logic              misaligned;
  logic [BEW-1:0]    be_base;
  logic [BEW-1:0]    be;
  logic [XLEN-1:0]   st_shifted;
  logic [XLEN-1:0]   st_data;
  logic              accept;
  logic              take_exc;
  logic              take_req;
  lsu_cause_e        cause;

  //////////////////////////////////////////////////
  // Address and alignment
  //////////////////////////////////////////////////

  // Effective address, rs1 plus immediate
  assign adr    = opa_i + imm_i;
  assign offset = adr[OFFW-1:0];

  always_comb
  begin
    case (width_i)
      LSU_W_BYTE: misaligned = 1'b0;
      LSU_W_HALF: misaligned = adr[0];
      LSU_W_WORD: misaligned = |adr[1:0];
      default:    misaligned = |adr[2:0];
    endcase
  end

  //////////////////////////////////////////////////
  // Byte lanes
  //////////////////////////////////////////////////

  // Contiguous mask for the width, from lane 0
  always_comb
  begin
    be_base = '0;
    case (width_i)
      LSU_W_BYTE: be_base[0]   = 1'b1;
      LSU_W_HALF: be_base[1:0] = 2'b11;
      LSU_W_WORD: be_base[3:0] = 4'hf;
      default:    be_base      = '1;
    endcase
  end

  assign be         = be_base << offset;
  assign st_shifted = opb_i << {offset, 3'b000};

  // Unused lanes go out as zero
  always_comb
  begin
    for (int i = 0; i < BEW; i++)
    begin
      st_data[8*i +: 8] = be[i] ? st_shifted[8*i +: 8] : 8'h00;
    end
  end

  //////////////////////////////////////////////////
  // Accept and exceptions
  //////////////////////////////////////////////////

  // Strobes during a stall are dropped
  assign accept   = insn_valid_i && (state == LSU_ST_IDLE) && (op_i != LSU_OP_NONE);
  assign take_exc = accept && (illegal_i || misaligned);
  assign take_req = accept && !illegal_i && !misaligned;

  always_comb
  begin
    if (illegal_i)
      cause = LSU_CAUSE_ILLEGAL_WIDTH;
    else if (op_i == LSU_OP_STORE)
      cause = LSU_CAUSE_STORE_MISALIGNED;
    else
      cause = LSU_CAUSE_LOAD_MISALIGNED;
  end

  //////////////////////////////////////////////////
  // Access FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state       <= LSU_ST_IDLE;
      dmem_req_o  <= 1'b0;
      ld_start_o  <= 1'b0;
      exc_valid_o <= 1'b0;
    end
    else
    begin
      // Pulses by default
      dmem_req_o  <= take_req;
      ld_start_o  <= take_req && (op_i == LSU_OP_LOAD);
      exc_valid_o <= take_exc;
      case (state)
        LSU_ST_IDLE:
          if (take_req)
            state <= LSU_ST_WAIT_ACK;
        default:
          if (dmem_ack_i)
            state <= LSU_ST_IDLE;
      endcase
    end
  end

  // Stall from the accept edge to the edge after ack
  assign lsu_stall_o = (state == LSU_ST_WAIT_ACK);

  // Request payload, held until the next request
  always_ff @(posedge clk_i)
  begin
    if (take_req)
    begin
      dmem_we_o     <= (op_i == LSU_OP_STORE);
      dmem_adr_o    <= adr;
      dmem_be_o     <= be;
      dmem_d_o      <= st_data;
      ld_width_o    <= width_i;
      ld_unsigned_o <= unsigned_i;
      ld_offset_o   <= offset;
    end
    if (take_exc)
    begin
      exc_cause_o <= cause;
      exc_addr_o  <= adr;
    end
  end

endmodule : lsu_issue

`default_nettype wire

//--- logic/lsu_load_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align
  import lsu_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  wire                        clk_i,
  input  wire                        rst_ni,

  // Load shape from issue
  input  wire                        ld_start_i,
  input  wire lsu_width_e            ld_width_i,
  input  wire                        ld_unsigned_i,
  input  wire [$clog2(XLEN/8)-1:0]   ld_offset_i,

  // Memory response
  input  wire                        dmem_ack_i,
  input  wire [XLEN-1:0]             dmem_q_i,

  output logic                       result_valid_o,
  output logic [XLEN-1:0]            result_o
);

  localparam int OFFW = $clog2(XLEN / 8);

  logic              pending;
  lsu_width_e        width_q;
  logic              unsigned_q;
  logic [OFFW-1:0]   offset_q;
  logic [XLEN-1:0]   shifted;
  logic [XLEN-1:0]   extended;
  logic              done;

  //////////////////////////////////////////////////
  // Pending load
  //////////////////////////////////////////////////

  // Store acks see no pending load
  assign done = dmem_ack_i && pending;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      pending        <= 1'b0;
      result_valid_o <= 1'b0;
    end
    else
    begin
      result_valid_o <= done;
      if (ld_start_i)
        pending <= 1'b1;
      else if (done)
        pending <= 1'b0;
    end
  end

  // Shape of the load in flight
  always_ff @(posedge clk_i)
  begin
    if (ld_start_i)
    begin
      width_q    <= ld_width_i;
      unsigned_q <= ld_unsigned_i;
      offset_q   <= ld_offset_i;
    end
  end

  //////////////////////////////////////////////////
  // Extract and extend
  //////////////////////////////////////////////////

  // Addressed byte down to lane 0
  assign shifted = dmem_q_i >> {offset_q, 3'b000};

  always_comb
  begin
    case (width_q)
      LSU_W_BYTE:
        extended = unsigned_q ? XLEN'(shifted[7:0]) : XLEN'($signed(shifted[7:0]));
      LSU_W_HALF:
        extended = unsigned_q ? XLEN'(shifted[15:0]) : XLEN'($signed(shifted[15:0]));
      LSU_W_WORD:
        extended = unsigned_q ? XLEN'(shifted[31:0]) : XLEN'($signed(shifted[31:0]));
      // Full register, nothing to extend
      default:
        extended = shifted;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (done)
      result_o <= extended;
  end

endmodule : lsu_load_align

`default_nettype wire

//--- logic/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top
  import lsu_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  wire                 clk_i,
  input  wire                 rst_ni,

  // Instruction strobe and operands
  input  wire                 insn_valid_i,
  input  wire [31:0]          insn_i,
  input  wire [XLEN-1:0]      opa_i,
  input  wire [XLEN-1:0]      opb_i,

  // Data memory
  output logic                dmem_req_o,
  output logic                dmem_we_o,
  output logic [XLEN-1:0]     dmem_adr_o,
  output logic [XLEN/8-1:0]   dmem_be_o,
  output logic [XLEN-1:0]     dmem_d_o,
  input  wire                 dmem_ack_i,
  input  wire [XLEN-1:0]      dmem_q_i,

  output logic                lsu_stall_o,
  output logic                result_valid_o,
  output logic [XLEN-1:0]     result_o,
  output logic                exc_valid_o,
  output lsu_cause_e          exc_cause_o,
  output logic [XLEN-1:0]     exc_addr_o
);

  localparam int OFFW = $clog2(XLEN / 8);

  //////////////////////////////////////////////////
  // Decode to issue
  //////////////////////////////////////////////////

  lsu_op_e           op;
  lsu_width_e        width;
  logic              is_unsigned;
  logic              illegal;
  logic [XLEN-1:0]   imm;

  // Issue to align
  logic              ld_start;
  lsu_width_e        ld_width;
  logic              ld_unsigned;
  logic [OFFW-1:0]   ld_offset;

  lsu_decode #(
    .XLEN (XLEN)
  ) u_decode (
    .insn_i     (insn_i),
    .op_o       (op),
    .width_o    (width),
    .unsigned_o (is_unsigned),
    .illegal_o  (illegal),
    .imm_o      (imm)
  );

  lsu_issue #(
    .XLEN (XLEN)
  ) u_issue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_valid_i  (insn_valid_i),
    .op_i          (op),
    .width_i       (width),
    .unsigned_i    (is_unsigned),
    .illegal_i     (illegal),
    .imm_i         (imm),
    .opa_i         (opa_i),
    .opb_i         (opb_i),
    .dmem_req_o    (dmem_req_o),
    .dmem_we_o     (dmem_we_o),
    .dmem_adr_o    (dmem_adr_o),
    .dmem_be_o     (dmem_be_o),
    .dmem_d_o      (dmem_d_o),
    .dmem_ack_i    (dmem_ack_i),
    .lsu_stall_o   (lsu_stall_o),
    .ld_start_o    (ld_start),
    .ld_width_o    (ld_width),
    .ld_unsigned_o (ld_unsigned),
    .ld_offset_o   (ld_offset),
    .exc_valid_o   (exc_valid_o),
    .exc_cause_o   (exc_cause_o),
    .exc_addr_o    (exc_addr_o)
  );

  // Load data path back to the core
  lsu_load_align #(
    .XLEN (XLEN)
  ) u_load_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ld_start_i     (ld_start),
    .ld_width_i     (ld_width),
    .ld_unsigned_i  (ld_unsigned),
    .ld_offset_i    (ld_offset),
    .dmem_ack_i     (dmem_ack_i),
    .dmem_q_i       (dmem_q_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

endmodule : lsu_top

`default_nettype wire

//--- tests/lsu_tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb_mem #(
  parameter int          XLEN = 32,
  parameter int unsigned SEED = 65142
) (
  input  wire                clk_i,
  input  wire                rst_ni,
  input  wire                req_i,
  input  wire                we_i,
  input  wire [XLEN-1:0]     adr_i,
  input  wire [XLEN/8-1:0]   be_i,
  input  wire [XLEN-1:0]     d_i,
  output logic               ack_o,
  output logic [XLEN-1:0]    q_o
);

  localparam int BEW  = XLEN / 8;
  localparam int OFFW = $clog2(BEW);

  logic [XLEN-1:0]   mem [256];
  int unsigned       rng;
  int                cnt;
  logic              busy;
  logic              we_q;
  logic [7:0]        idx_q;
  logic [BEW-1:0]    be_q;
  logic [XLEN-1:0]   d_q;

  // Latency stream of its own
  function automatic int unsigned xorshift(input int unsigned x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Fill depends on the whole word index
  initial
  begin
    for (int i = 0; i < 256; i++)
      mem[i] = {(XLEN/32){(32'(i) * 32'h9e3779b1) ^ 32'h0f1e2d3c ^ (32'(i) << 16)}};
  end

  // Responder runs on the falling edge like the other drivers
  always @(negedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ack_o <= 1'b0;
      q_o   <= '0;
      busy  <= 1'b0;
      cnt   <= 0;
      rng   = SEED;
    end
    else
    begin
      ack_o <= 1'b0;
      if (req_i)
      begin
        rng = xorshift(rng);
        // 0..3 extra cycles, so 1 to 4 in all
        cnt   <= int'(rng % 4);
        busy  <= 1'b1;
        we_q  <= we_i;
        idx_q <= adr_i[OFFW+7:OFFW];
        be_q  <= be_i;
        d_q   <= d_i;
      end
      else if (busy)
      begin
        if (cnt == 0)
        begin
          ack_o <= 1'b1;
          q_o   <= mem[idx_q];
          busy  <= 1'b0;
          // Only enabled byte lanes are written
          if (we_q)
            for (int i = 0; i < BEW; i++)
              if (be_q[i])
                mem[idx_q][8*i +: 8] <= d_q[8*i +: 8];
        end
        else
          cnt <= cnt - 1;
      end
    end
  end

endmodule : lsu_tb_mem

`default_nettype wire

//--- tests/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

  localparam int XLEN  = 32;
  localparam int BEW   = XLEN / 8;
  localparam int FULLW = (XLEN == 64) ? 3 : 2;
  localparam logic [6:0] LOAD_OPC  = 7'b0000011;
  localparam logic [6:0] STORE_OPC = 7'b0100011;

  logic clk_i, rst_ni, insn_valid_i;
  logic [31:0] insn_i;
  logic [XLEN-1:0] opa_i, opb_i;
  logic dmem_req_o, dmem_we_o, dmem_ack_i;
  logic [XLEN-1:0] dmem_adr_o, dmem_d_o, dmem_q_i, result_o, exc_addr_o;
  logic [BEW-1:0] dmem_be_o;
  logic lsu_stall_o, result_valid_o, exc_valid_o;
  logic [1:0] exc_cause_o;

  // Shadow memory and monitor state
  logic [XLEN-1:0] shadow [256];
  int unsigned rng = 65142;
  int errors, checks, req_cnt, res_cnt, exc_cnt, stall_cnt;
  logic cap_we;
  logic [XLEN-1:0] cap_adr, cap_d, cap_res, cap_eaddr;
  logic [BEW-1:0] cap_be;
  logic [1:0] cap_cause;
  // Stall one sample before the result and at the result
  logic [1:0] cap_stall;
  logic stall_prev;

  lsu_top #(.XLEN(XLEN)) lsu_top_i (
    .clk_i, .rst_ni, .insn_valid_i, .insn_i, .opa_i, .opb_i,
    .dmem_req_o, .dmem_we_o, .dmem_adr_o, .dmem_be_o, .dmem_d_o, .dmem_ack_i, .dmem_q_i,
    .lsu_stall_o, .result_valid_o, .result_o, .exc_valid_o, .exc_cause_o, .exc_addr_o
  );

  lsu_tb_mem #(.XLEN(XLEN), .SEED(65142 ^ 32'h5a5a)) mem_i (
    .clk_i, .rst_ni, .req_i(dmem_req_o), .we_i(dmem_we_o), .adr_i(dmem_adr_o),
    .be_i(dmem_be_o), .d_i(dmem_d_o), .ack_o(dmem_ack_i), .q_o(dmem_q_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic int unsigned xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s got %h expected %h", name, got, exp);
    end
  endtask

  // Advance one cycle and sample outputs on the falling edge
  task automatic step();
    @(negedge clk_i);
    if (dmem_req_o)
    begin
      req_cnt++;
      {cap_we, cap_adr, cap_be, cap_d} = {dmem_we_o, dmem_adr_o, dmem_be_o, dmem_d_o};
    end
    if (result_valid_o)
    begin
      res_cnt++;
      cap_res = result_o;
      cap_stall = {stall_prev, lsu_stall_o};
    end
    if (exc_valid_o)
    begin
      exc_cnt++;
      {cap_cause, cap_eaddr} = {exc_cause_o, exc_addr_o};
    end
    if (lsu_stall_o)
      stall_cnt++;
    stall_prev = lsu_stall_o;
  endtask

  function automatic bit reached(input int kind, input int target);
    if (kind == 0)
      return exc_cnt >= target;
    if (kind == 1)
      return res_cnt >= target;
    return (req_cnt >= target) && !lsu_stall_o;
  endfunction

  // Bounded wait for an exception (0), a result (1) or the stall release (2)
  task automatic wait_for(input int kind, input int target);
    for (int n = 0; n < 50 && !reached(kind, target); n++)
      step();
    if (!reached(kind, target))
    begin
      $display("Timeout: the unit stalled, no %s within 50 cycles",
               kind == 0 ? "exception" : kind == 1 ? "load result" : "store completion");
      $display("Done: errors found");
      $finish;
    end
  endtask

  // Expected load value from the shadow copy
  function automatic logic [XLEN-1:0] load_expect(input logic [XLEN-1:0] adr,
                                                   input int w, input bit uns);
    logic [XLEN-1:0] word;
    logic [XLEN-1:0] res;
    int off;
    int nb;
    bit sign;
    word = shadow[(adr / BEW) % 256];
    off  = int'(adr % BEW);
    nb   = 1 << w;
    sign = !uns && word[8*(off+nb)-1];
    for (int i = 0; i < BEW; i++)
      res[8*i +: 8] = (i < nb) ? word[8*(off+i) +: 8] : {8{sign}};
    return res;
  endfunction

  // Replicate the top immediate bit
  function automatic logic [XLEN-1:0] sext12(input logic [11:0] v);
    return {{(XLEN-12){v[11]}}, v};
  endfunction

  //////////////////////////////////////////////////
  // Reference model and one instruction
  //////////////////////////////////////////////////

  task automatic run_insn(input logic [31:0] insn, input logic [XLEN-1:0] a, b);
    logic [2:0] f3;
    int w, kind, off, q0, r0, e0, s0;
    bit uns, ill, mis;
    logic [XLEN-1:0] adr, exp_d;
    logic [BEW-1:0] exp_be;
    f3   = insn[14:12];
    w    = f3[1:0];
    uns  = f3[2];
    kind = (insn[6:0] == LOAD_OPC) ? 1 : (insn[6:0] == STORE_OPC) ? 2 : 0;
    ill  = (kind != 0) && ((XLEN == 32 && w == 3) || (uns && (w == FULLW || kind == 2)));
    adr  = a + ((kind == 2) ? sext12({insn[31:25], insn[11:7]}) : sext12(insn[31:20]));
    mis  = (adr % (1 << w)) != 0;
    off  = int'(adr % BEW);
    // Lanes of the access and the data moved into them
    for (int i = 0; i < BEW; i++)
    begin
      exp_be[i] = (i >= off) && (i < off + (1 << w));
      exp_d[8*i +: 8] = exp_be[i] ? b[8*(i-off) +: 8] : 8'h00;
    end
    {q0, r0, e0} = {req_cnt, res_cnt, exc_cnt};
    s0 = stall_cnt;
    {insn_valid_i, insn_i, opa_i, opb_i} = {1'b1, insn, a, b};
    step();
    insn_valid_i = 1'b0;
    if (kind != 0 && (ill || mis))
    begin
      wait_for(0, e0 + 1);
      compare("exc_cause_o", cap_cause, ill ? 2 : (kind == 2) ? 1 : 0);
      compare("exc_addr_o", cap_eaddr, adr);
      repeat (3) step();
      compare("exc_count", exc_cnt, e0 + 1);
      compare("req_count", req_cnt, q0);
      // No stall for a rejected access
      compare("stall_count", stall_cnt, s0);
    end
    else if (kind == 2)
    begin
      wait_for(2, q0 + 1);
      compare("dmem_we_o", cap_we, 1);
      compare("dmem_adr_o", cap_adr, adr);
      compare("dmem_be_o", cap_be, exp_be);
      compare("dmem_d_o", cap_d, exp_d);
      compare("req_count", req_cnt, q0 + 1);
      compare("result_count", res_cnt, r0);
      for (int i = 0; i < BEW; i++)
        if (exp_be[i])
          shadow[(adr / BEW) % 256][8*i +: 8] = exp_d[8*i +: 8];
    end
    else if (kind == 1)
    begin
      wait_for(1, r0 + 1);
      compare("dmem_we_o", cap_we, 0);
      compare("dmem_adr_o", cap_adr, adr);
      compare("dmem_be_o", cap_be, exp_be);
      compare("result_o", cap_res, load_expect(adr, w, uns));
      // Stall falls on the edge that raises the result
      compare("lsu_stall_o", cap_stall, 2'b10);
      repeat (2) step();
      compare("result_count", res_cnt, r0 + 1);
      compare("req_count", req_cnt, q0 + 1);
    end
    else
    begin
      // Nothing may come out of a bubble
      repeat (4) step();
      compare("req_count", req_cnt, q0);
      compare("result_count", res_cnt, r0);
      compare("exc_count", exc_cnt, e0);
    end
  endtask

  // Memory access with a random immediate reaching the target address
  task automatic access(input bit store, input logic [2:0] f3, input logic [XLEN-1:0] target);
    logic [11:0] imm;
    logic [31:0] insn;
    imm  = 12'(xorshift());
    insn = store ? {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], STORE_OPC}
                 : {imm, 5'd1, f3, 5'd2, LOAD_OPC};
    run_insn(insn, target - sext12(imm), XLEN'({xorshift(), xorshift()}));
  endtask

  function automatic logic [XLEN-1:0] aligned_adr(input int w);
    return XLEN'((xorshift() % 256) * BEW + ((xorshift() % BEW) & ~((1 << w) - 1)));
  endfunction

  task automatic stall_drop();
    int q0, r0, e0;
    logic [XLEN-1:0] adr;
    adr = aligned_adr(2);
    {q0, r0, e0} = {req_cnt, res_cnt, exc_cnt};
    {insn_valid_i, insn_i, opa_i} = {1'b1, 12'd0, 5'd1, 3'b010, 5'd2, LOAD_OPC, adr};
    step();
    compare("lsu_stall_o", lsu_stall_o, 1);
    // Store strobe during the stall must be dropped
    {insn_i, opb_i} = {7'd0, 5'd3, 5'd1, 3'b010, 5'd0, STORE_OPC, XLEN'(xorshift())};
    step();
    insn_valid_i = 1'b0;
    wait_for(1, r0 + 1);
    repeat (6) step();
    compare("result_o", cap_res, load_expect(adr, 2, 0));
    compare("req_count", req_cnt, q0 + 1);
    compare("exc_count", exc_cnt, e0);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial
  begin
    int e0;
    {rst_ni, insn_valid_i, insn_i, opa_i, opb_i} = '0;
    for (int i = 0; i < 256; i++)
      shadow[i] = {(XLEN/32){(32'(i) * 32'h9e3779b1) ^ 32'h0f1e2d3c ^ (32'(i) << 16)}};
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    // 1. Quiet after reset
    e0 = errors;
    repeat (20) step();
    compare("quiet_activity", req_cnt + res_cnt + exc_cnt + stall_cnt, 0);
    $display("test 1 reset idle: %0d errors", errors - e0);

    // 2. Aligned stores of every legal width
    e0 = errors;
    for (int w = 0; w <= FULLW; w++)
      repeat (8) access(1, 3'(w), aligned_adr(w));
    $display("test 2 aligned stores: %0d errors", errors - e0);

    // 3. Aligned loads in all legal signed and unsigned forms
    e0 = errors;
    for (int f = 0; f < 8; f++)
      if ((f % 4) <= FULLW && !(f >= 4 && (f % 4) == FULLW))
        repeat (8) access(0, 3'(f), aligned_adr(f % 4));
    $display("test 3 aligned loads: %0d errors", errors - e0);

    // 4. Misaligned addresses and illegal widths
    e0 = errors;
    repeat (6)
    begin
      access(0, 3'b001, aligned_adr(0) | 1);
      access(1, 3'b010, aligned_adr(0) | 1);
      access(0, 3'b000 | 3'(FULLW) | 3'b100, aligned_adr(FULLW));
      access(1, 3'b100, aligned_adr(0));
      access(0, 3'b011, aligned_adr(FULLW));
    end
    $display("test 4 exceptions: %0d errors", errors - e0);

    // 5. Bubbles and strobes during a stall
    e0 = errors;
    repeat (10)
      run_insn({xorshift()} & 32'hffff_ff80 | 32'h13, XLEN'(xorshift()), XLEN'(xorshift()));
    repeat (4) stall_drop();
    $display("test 5 ignored strobes: %0d errors", errors - e0);

    // 6. Random mix with random memory latency
    e0 = errors;
    repeat (400)
    begin
      case (xorshift() % 8)
        0:       run_insn(32'h33 | (xorshift() & 32'hffff_ff00), XLEN'(xorshift()), '0);
        1, 2, 3: access(0, 3'(xorshift()), XLEN'(xorshift() % (256 * BEW)));
        default: access(1, 3'(xorshift()), XLEN'(xorshift() % (256 * BEW)));
      endcase
    end
    $display("test 6 random mix: %0d errors", errors - e0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule : lsu_tb

`default_nettype wire

//--- lsu_sys.f
logic/lsu_pkg.sv
logic/lsu_decode.sv
logic/lsu_issue.sv
logic/lsu_load_align.sv
logic/lsu_top.sv
tests/lsu_tb_mem.sv
tests/lsu_tb.sv

//--- Makefile
# Verilator flow for lsu_sys
# All variables can be overridden on the command line

VERILATOR ?= verilator
FLIST     ?= lsu_sys.f
TB_TOP    ?= lsu_tb
RTL_TOP   ?= lsu_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TB_TOP)
	$(VERILATOR) --lint-only -f $(FLIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
	  (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
